// File: dds_pkg.sv
package dds_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////

   localparam int PHASE_W     = 32;               // phase accumulator and tuning word
   localparam int LUT_ADDR_W  = 6;                // top phase bits into the sine table
   localparam int LUT_DEPTH   = 2 ** LUT_ADDR_W;
   localparam int LUT_QUARTER = LUT_DEPTH / 4;    // 90 degree address offset
   localparam int SAMPLE_W    = 12;               // two's complement samples
   localparam int PLOT_W      = 8;
   localparam int PLOT_LSB    = SAMPLE_W - PLOT_W; // lowest sample bit kept for plots
   localparam int LFSR_W      = 5;

   ////////////////////////////////////////////////////////////
   // select codes
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      MOD_ASK  = 2'd0,
      MOD_FSK  = 2'd1,
      MOD_BPSK = 2'd2,
      MOD_QPSK = 2'd3
   } mod_sel_t;

   typedef enum logic [1:0] {
      SIG_SIN  = 2'd0,
      SIG_COS  = 2'd1,
      SIG_SAW  = 2'd2,
      SIG_LFSR = 2'd3
   } sig_sel_t;

   // full scale levels for one data bit
   localparam logic [SAMPLE_W-1:0] LEVEL_HIGH = 12'h7FF;
   localparam logic [SAMPLE_W-1:0] LEVEL_LOW  = 12'h800;

   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;

endpackage

// File: wave_if.sv
`timescale 1ns/1ps

// dds outputs and the data bits that were current for them
interface wave_if;

   logic [dds_pkg::SAMPLE_W-1:0] sin;
   logic [dds_pkg::SAMPLE_W-1:0] cos;
   logic [dds_pkg::SAMPLE_W-1:0] saw;
   logic [dds_pkg::SAMPLE_W-1:0] squ;
   logic [1:0]                   bits;   // aligned with the samples

   modport src (
      output sin,
      output cos,
      output saw,
      output squ,
      output bits
   );

   modport dst (
      input sin,
      input cos,
      input saw,
      input squ,
      input bits
   );

endinterface

// File: bit_source.sv
`timescale 1ns/1ps

module bit_source
   import dds_pkg::*;
#(
   parameter int BIT_DIV = 64
) (
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   output logic [1:0] data_bits
);

   localparam int DIV_W = (BIT_DIV > 1) ? $clog2(BIT_DIV) : 1;

   logic [DIV_W-1:0]  div_cnt;
   logic              bit_tick;
   logic [LFSR_W-1:0] lfsr;

   ////////////////////////////////////////////////////////////
   // bit rate divider
   ////////////////////////////////////////////////////////////

   assign bit_tick = (div_cnt == DIV_W'(BIT_DIV - 1));

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         div_cnt <= '0;
      end else if (bit_tick) begin
         div_cnt <= '0;   // wrap, one tick per bit period
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // lfsr, x^5 + x^3 + 1, period 31
   ////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         lfsr <= LFSR_SEED;
      end else if (bit_tick) begin
         lfsr <= {lfsr[LFSR_W-2:0], lfsr[4] ^ lfsr[2]};
      end
   end

   assign data_bits = lfsr[1:0];   // low pair drives the keying

   // the all zero state would lock the sequence up for good
   lfsr_not_zero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr != '0);

endmodule

// File: phase_wave_gen.sv
`timescale 1ns/1ps

module phase_wave_gen
   import dds_pkg::*;
(
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  mod_sel_t           mod_select,
   input  logic [PHASE_W-1:0] carrier_word,
   input  logic [PHASE_W-1:0] fsk_space_word,
   input  logic [1:0]         data_bits,
   wave_if.src                wave
);

   logic [SAMPLE_W-1:0]   sine_rom [0:LUT_DEPTH-1];
   logic [PHASE_W-1:0]    phase;
   logic [PHASE_W-1:0]    tuning_word;
   logic [LUT_ADDR_W-1:0] sin_addr;
   logic [LUT_ADDR_W-1:0] cos_addr;

   initial begin
      $readmemh("sine_table.hex", sine_rom);
   end

   ////////////////////////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////////////////////////

   // space frequency only while FSK sends a zero
   assign tuning_word = (mod_select == MOD_FSK && !data_bits[0]) ? fsk_space_word
                                                                 : carrier_word;

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         phase <= '0;
      end else begin
         phase <= phase + tuning_word;
      end
   end

   ////////////////////////////////////////////////////////////
   // waveform derivation
   ////////////////////////////////////////////////////////////

   assign sin_addr = phase[PHASE_W-1 -: LUT_ADDR_W];
   assign cos_addr = sin_addr + LUT_ADDR_W'(LUT_QUARTER);   // quarter turn ahead, wraps

   // one register stage, bits travel with the samples
   always_ff @(posedge CLK_25MHZ) begin
      wave.sin  <= sine_rom[sin_addr];
      wave.cos  <= sine_rom[cos_addr];
      wave.saw  <= {~phase[PHASE_W-1], phase[PHASE_W-2 -: SAMPLE_W-1]};   // offset to signed
      wave.bits <= data_bits;

      if (phase[PHASE_W-1]) begin
         wave.squ <= LEVEL_LOW;    // second half of the period
      end else begin
         wave.squ <= LEVEL_HIGH;
      end
   end

endmodule

// File: keying_modulator.sv
`timescale 1ns/1ps

module keying_modulator
   import dds_pkg::*;
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  mod_sel_t            mod_select,
   input  sig_sel_t            sig_select,
   wave_if.dst                 wave,
   output logic [SAMPLE_W-1:0] mod_out,
   output logic [SAMPLE_W-1:0] sig_out
);

   logic [SAMPLE_W-1:0] neg_sin;
   logic [SAMPLE_W-1:0] neg_cos;
   logic [SAMPLE_W-1:0] sin_rot;
   logic [SAMPLE_W-1:0] cos_rot;
   logic [SAMPLE_W-1:0] saw_rot;
   logic [SAMPLE_W-1:0] lfsr_level;

   assign neg_sin = -wave.sin;
   assign neg_cos = -wave.cos;

   ////////////////////////////////////////////////////////////
   // qpsk rotation by a quarter turn per step of the bit pair
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (wave.bits)
         2'd0: begin
            sin_rot = wave.sin;
            cos_rot = wave.cos;
         end
         2'd1: begin
            sin_rot = wave.cos;
            cos_rot = neg_sin;
         end
         2'd2: begin
            sin_rot = neg_sin;
            cos_rot = neg_cos;
         end
         default: begin
            sin_rot = neg_cos;
            cos_rot = wave.sin;
         end
      endcase
   end

   // saw shifted by the same quarter turns through its top two bits
   assign saw_rot = wave.saw + {wave.bits, {(SAMPLE_W-2){1'b0}}};

   assign lfsr_level = wave.bits[0] ? LEVEL_HIGH : LEVEL_LOW;

   ////////////////////////////////////////////////////////////
   // output stage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         mod_out <= '0;
         sig_out <= '0;
      end else begin
         case (mod_select)
            MOD_ASK:  mod_out <= wave.bits[0] ? wave.sin : '0;      // on off keying
            MOD_FSK:  mod_out <= wave.sin;                          // frequency set upstream
            MOD_BPSK: mod_out <= wave.bits[0] ? wave.sin : neg_sin;
            default:  mod_out <= sin_rot;
         endcase

         case (sig_select)
            SIG_SIN: sig_out <= (mod_select == MOD_QPSK) ? sin_rot : wave.sin;
            SIG_COS: sig_out <= (mod_select == MOD_QPSK) ? cos_rot : wave.cos;
            SIG_SAW: sig_out <= (mod_select == MOD_QPSK) ? saw_rot : wave.saw;
            default: sig_out <= lfsr_level;
         endcase
      end
   end

   // selects come straight from the top level pins
   sel_known: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !$isunknown({mod_select, sig_select}));

endmodule

// File: scope_sampler.sv
`timescale 1ns/1ps

module scope_sampler
   import dds_pkg::*;
#(
   parameter int SAMPLE_DIV = 16
) (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  logic [SAMPLE_W-1:0] mod_out,
   input  logic [SAMPLE_W-1:0] sig_out,
   output logic [PLOT_W-1:0]   plot_mod,
   output logic [PLOT_W-1:0]   plot_sig,
   output logic                plot_strobe
);

   localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic             sample_tick;

   // signed sample to offset binary, keep the top PLOT_W bits
   function automatic logic [PLOT_W-1:0] to_plot(input logic [SAMPLE_W-1:0] s);
      return {~s[SAMPLE_W-1], s[SAMPLE_W-2:PLOT_LSB]};
   endfunction

   assign sample_tick = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         div_cnt     <= '0;
         plot_strobe <= 1'b0;
         plot_mod    <= '0;
         plot_sig    <= '0;
      end else begin
         div_cnt     <= sample_tick ? '0 : div_cnt + 1'b1;
         plot_strobe <= sample_tick;   // one clock wide
         if (sample_tick) begin
            plot_mod <= to_plot(mod_out);
            plot_sig <= to_plot(sig_out);
         end
      end
   end

   strobe_one_clock: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      plot_strobe |=> !plot_strobe);

endmodule

// File: dds_modem_top.sv
`timescale 1ns/1ps

module dds_modem_top
   import dds_pkg::*;
#(
   parameter int BIT_DIV    = 64,   // clocks per data bit
   parameter int SAMPLE_DIV = 16    // clocks per scope sample
) (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  mod_sel_t           mod_select,
   input  sig_sel_t           sig_select,
   input  logic [PHASE_W-1:0] carrier_word,
   input  logic [PHASE_W-1:0] fsk_space_word,
   output logic [1:0]         data_bits,
   output logic [PLOT_W-1:0]  plot_mod,
   output logic [PLOT_W-1:0]  plot_sig,
   output logic               plot_strobe
);

   logic [SAMPLE_W-1:0] mod_out;
   logic [SAMPLE_W-1:0] sig_out;

   wave_if wave_bus ();

   ////////////////////////////////////////////////////////////
   // bits -> dds -> keying -> scope
   ////////////////////////////////////////////////////////////

   bit_source #(.BIT_DIV(BIT_DIV)) u_bit_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .data_bits      (data_bits)
   );

   phase_wave_gen u_phase_wave_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mod_select     (mod_select),
      .carrier_word   (carrier_word),
      .fsk_space_word (fsk_space_word),
      .data_bits      (data_bits),
      .wave           (wave_bus.src)
   );

   keying_modulator u_keying_modulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mod_select     (mod_select),
      .sig_select     (sig_select),
      .wave           (wave_bus.dst),
      .mod_out        (mod_out),
      .sig_out        (sig_out)
   );

   scope_sampler #(.SAMPLE_DIV(SAMPLE_DIV)) u_scope_sampler (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mod_out        (mod_out),
      .sig_out        (sig_out),
      .plot_mod       (plot_mod),
      .plot_sig       (plot_sig),
      .plot_strobe    (plot_strobe)
   );

endmodule

// File: tb_dds_modem.sv
`timescale 1ns/1ps

module tb_dds_modem
   import dds_pkg::*;
;

   localparam int BIT_DIV    = 64;
   localparam int SAMPLE_DIV = 16;
   localparam int SEG_CYC    = 8 * BIT_DIV;          // one test segment
   localparam int TOTAL_CYC  = 11 * SEG_CYC + 8;     // eleven segments plus reset
   localparam int WATCH_NS   = TOTAL_CYC * 40 * 3 / 2;

   logic               CLK_25MHZ = 1'b0;
   logic               reset_from_key;
   mod_sel_t           mod_select;
   sig_sel_t           sig_select;
   logic [PHASE_W-1:0] carrier_word;
   logic [PHASE_W-1:0] fsk_space_word;
   logic [1:0]         data_bits;
   logic [PLOT_W-1:0]  plot_mod;
   logic [PLOT_W-1:0]  plot_sig;
   logic               plot_strobe;

   logic [SAMPLE_W-1:0] sine_tab [0:LUT_DEPTH-1];
   logic [31:0]         rng = 32'h8953;
   int                  n_checks = 0;
   int                  n_errors = 0;

   // cycle model state, always the value after the last edge
   int                  e_cnt;
   int                  lfsr_steps;
   int                  last_strobe;
   logic [4:0]          m_lfsr;
   logic [PHASE_W-1:0]  m_phase;
   logic [PHASE_W-1:0]  w_phase;    // phase behind the wave registers
   logic [1:0]          w_bits;
   logic                k_valid;
   mod_sel_t            k_mode;
   sig_sel_t            k_sel;
   logic [PHASE_W-1:0]  k_phase;
   logic [1:0]          k_bits;
   logic                m_strobe;
   logic [PLOT_W-1:0]   m_pmod;
   logic [PLOT_W-1:0]   m_psig;
   logic [3:0]          qpsk_seen = 4'h0;

   always #20 CLK_25MHZ = ~CLK_25MHZ;

   dds_modem_top #(.BIT_DIV(BIT_DIV), .SAMPLE_DIV(SAMPLE_DIV)) dut0 (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mod_select     (mod_select),
      .sig_select     (sig_select),
      .carrier_word   (carrier_word),
      .fsk_space_word (fsk_space_word),
      .data_bits      (data_bits),
      .plot_mod       (plot_mod),
      .plot_sig       (plot_sig),
      .plot_strobe    (plot_strobe)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [PLOT_W-1:0] offset_plot(input logic [SAMPLE_W-1:0] s);
      return {~s[11], s[10:4]};   // flip sign bit, keep top bits
   endfunction

   ////////////////////////////////////////////////////////////
   // reference: expected {plot_mod, plot_sig}
   ////////////////////////////////////////////////////////////

   function automatic logic [15:0] plot_ref(input mod_sel_t mode, input sig_sel_t sel,
                                            input logic [31:0] ph, input logic [1:0] b);
      logic [5:0]  a;
      logic [11:0] s;
      logic [11:0] c;
      logic [11:0] car;
      logic [11:0] rs;
      logic [31:0] ph_rot;
      a = ph[31:26];
      s = sine_tab[a];
      c = sine_tab[a + 6'd16];
      ph_rot = (mode == MOD_QPSK) ? ph + {b, 30'b0} : ph;   // quarter turns for the saw
      case (mode)
         MOD_ASK:  car = b[0] ? s : 12'h000;
         MOD_FSK:  car = s;
         MOD_BPSK: car = b[0] ? s : -s;
         default: begin
            case (b)
               2'd0:    car = s;
               2'd1:    car = c;
               2'd2:    car = -s;
               default: car = -c;
            endcase
         end
      endcase
      case (sel)
         SIG_SIN: rs = (mode == MOD_QPSK) ? car : s;
         SIG_COS: begin
            rs = c;
            if (mode == MOD_QPSK) begin
               case (b)
                  2'd1:    rs = -s;
                  2'd2:    rs = -c;
                  2'd3:    rs = s;
                  default: rs = c;
               endcase
            end
         end
         SIG_SAW: rs = {~ph_rot[31], ph_rot[30:20]};
         default: rs = b[0] ? 12'h7FF : 12'h800;
      endcase
      return {offset_plot(car), offset_plot(rs)};
   endfunction

   ////////////////////////////////////////////////////////////
   // compare, then advance the model by one clock
   ////////////////////////////////////////////////////////////

   always @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         e_cnt = 0;
         lfsr_steps = 0;
         last_strobe = 0;
         m_lfsr = 5'b00001;
         m_phase = '0;
         w_phase = '0;
         w_bits = 2'b01;
         k_valid = 1'b0;
         m_strobe = 1'b0;
         m_pmod = '0;
         m_psig = '0;
      end else begin
         n_checks = n_checks + 1;
         assert (data_bits === m_lfsr[1:0]) else begin
            $display("** Error data_bits: expected %h, got %h", m_lfsr[1:0], data_bits);
            n_errors = n_errors + 1;
         end
         assert (plot_strobe === m_strobe) else begin
            $display("** Error plot_strobe: expected %h, got %h", m_strobe, plot_strobe);
            n_errors = n_errors + 1;
         end
         assert (plot_mod === m_pmod) else begin
            $display("** Error plot_mod: expected %h, got %h", m_pmod, plot_mod);
            n_errors = n_errors + 1;
         end
         assert (plot_sig === m_psig) else begin
            $display("** Error plot_sig: expected %h, got %h", m_psig, plot_sig);
            n_errors = n_errors + 1;
         end
         if (plot_strobe === 1'b1) begin
            assert (e_cnt - last_strobe == SAMPLE_DIV) else begin
               $display("strobe came %0d clocks after the previous one",
                        e_cnt - last_strobe);
               n_errors = n_errors + 1;
            end
            last_strobe = e_cnt;
         end
         if (lfsr_steps > 0 && lfsr_steps % 31 == 0) begin
            assert (data_bits === 2'b01) else begin
               $display("data bit sequence did not return to the seed after 31 steps");
               n_errors = n_errors + 1;
            end
         end

         e_cnt = e_cnt + 1;
         m_strobe = (e_cnt % SAMPLE_DIV == 0);
         if (m_strobe) begin
            {m_pmod, m_psig} = k_valid ? plot_ref(k_mode, k_sel, k_phase, k_bits) : 16'h8080;
            if (k_mode == MOD_QPSK)
               qpsk_seen[k_bits] = 1'b1;
         end
         k_mode = mod_select;   // keying stage
         k_sel = sig_select;
         k_phase = w_phase;
         k_bits = w_bits;
         k_valid = 1'b1;
         w_phase = m_phase;     // wave stage
         w_bits = m_lfsr[1:0];
         if (mod_select == MOD_FSK && !m_lfsr[0])
            m_phase = m_phase + fsk_space_word;
         else
            m_phase = m_phase + carrier_word;
         if (e_cnt % BIT_DIV == 0) begin
            m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
            lfsr_steps = lfsr_steps + 1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus, inputs change on the falling edge
   ////////////////////////////////////////////////////////////

   task automatic run_segment(input mod_sel_t mode, input sig_sel_t sel);
      rng = lcg_next(rng);
      carrier_word = rng;
      rng = lcg_next(rng);
      fsk_space_word = rng;
      mod_select = mode;
      sig_select = sel;
      repeat (SEG_CYC) @(negedge CLK_25MHZ);
   endtask

   initial begin
      $readmemh("sine_table.hex", sine_tab);
      reset_from_key = 1'b1;
      mod_select = MOD_ASK;
      sig_select = SIG_LFSR;
      carrier_word = '0;
      fsk_space_word = '0;
      repeat (2) @(posedge CLK_25MHZ);
      @(negedge CLK_25MHZ);
      reset_from_key = 1'b0;
      repeat (4) run_segment(MOD_ASK, SIG_LFSR);   // also spans a full lfsr period
      run_segment(MOD_BPSK, SIG_COS);
      run_segment(MOD_BPSK, SIG_SAW);
      run_segment(MOD_FSK, SIG_SIN);
      run_segment(MOD_FSK, SIG_SAW);
      run_segment(MOD_QPSK, SIG_SIN);
      run_segment(MOD_QPSK, SIG_COS);
      run_segment(MOD_QPSK, SIG_SAW);
      assert (qpsk_seen == 4'hF) else begin
         $display("not every bit pair was sampled in QPSK mode");
         n_errors = n_errors + 1;
      end
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      #(WATCH_NS);
      $display("watchdog: run did not end within %0d ns", WATCH_NS);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: sine_table.hex
// one 12-bit two's complement sine sample per line, amplitude 2047
// line n holds sin(2*pi*n/64), n = 0 to 63 over one full period
000
0C9
18F
252
30F
3C5
471
513
5A7
62E
6A6
70D
763
7A7
7D8
7F5
7FF
7F5
7D8
7A7
763
70D
6A6
62E
5A7
513
471
3C5
30F
252
18F
0C9
000
F37
E71
DAE
CF1
C3B
B8F
AED
A59
9D2
95A
8F3
89D
859
828
80B
801
80B
828
859
89D
8F3
95A
9D2
A59
AED
B8F
C3B
CF1
DAE
E71
F37

// File: all.f
dds_pkg.sv
wave_if.sv
bit_source.sv
phase_wave_gen.sv
keying_modulator.sv
scope_sampler.sv
dds_modem_top.sv
tb_dds_modem.sv

// File: Bender.yml
package:
  name: dds_modem

dependencies: {}

sources:
  - dds_pkg.sv
  - wave_if.sv
  - bit_source.sv
  - phase_wave_gen.sv
  - keying_modulator.sv
  - scope_sampler.sv
  - dds_modem_top.sv
  - target: test
    files:
      - tb_dds_modem.sv
